// File: common/core_types_pkg.sv
// core-side load queue tag type

package core_types_pkg;

	// load queue index
	// sent with a data read, echoed back on its response
	// 8 entries in the load queue
	typedef logic [2:0] lq_index_t;

	// response carries the tag unchanged
	// so the core can complete out of order

endpackage

// File: common/mem_types_pkg.sv
// memory-side word and data address types, byte address padding constants

package mem_types_pkg;

	////////////////////////////////////////////////////////////
	// widths
	////////////////////////////////////////////////////////////

	// data word, also used for byte addresses
	typedef logic [31:0] word_t;

	// word address of a data access
	// 16k words, upper byte address bits are always zero
	typedef logic [13:0] daddr_t;

	////////////////////////////////////////////////////////////
	// address padding
	////////////////////////////////////////////////////////////

	// zero bits above a daddr_t in a byte address
	localparam logic [15:0] DADDR_HI_PAD = 16'h0000;

	// byte offset of a word access
	localparam logic [1:0] DADDR_LO_PAD = 2'b00;

	// byte address = {DADDR_HI_PAD, daddr_t, DADDR_LO_PAD}
	// 16 + 14 + 2 = 32 bits

endpackage

// File: design/hang_detector.sv
// hang detector: free-running cycle counter with sticky hang flag

`timescale 1ns/1ps

module hang_detector #(
	parameter int HANG_COUNT_WIDTH = 16
) (
	input  logic CLK,
	input  logic nRST,
	output logic hang
);

	logic [HANG_COUNT_WIDTH-1:0] cycle_count;

	// count from reset release
	// flag set on the edge after all ones, then held
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			cycle_count <= '0;
			hang        <= 1'b0;
		end else begin
			cycle_count <= cycle_count + 1'b1;
			if (cycle_count == '1) begin
				hang <= 1'b1;
			end
		end
	end

endmodule

// File: design/ram.sv
// word RAM: asynchronous read, synchronous write, cleared on reset

`timescale 1ns/1ps

module ram #(
	parameter int RAM_WORDS_LOG2 = 14
) (
	input  logic                 CLK,
	input  logic                 nRST,
	input  logic                 ren,
	input  logic                 wen,
	input  mem_types_pkg::word_t addr,
	input  mem_types_pkg::word_t store,
	output mem_types_pkg::word_t load
);

	localparam int WORDS = 1 << RAM_WORDS_LOG2;

	mem_types_pkg::word_t mem [WORDS];
	logic [RAM_WORDS_LOG2-1:0] word_idx;

	// byte address to word index
	assign word_idx = addr[RAM_WORDS_LOG2+1:2];

	// always ready, read in the same cycle
	assign load = ren ? mem[word_idx] : '0;

	// write lands at the edge, seen next cycle
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			mem <= '{default: '0};
		end else if (wen) begin
			mem[word_idx] <= store;
		end
	end

endmodule

// File: design/system.sv
// system top: arbiter, RAM, hang detector, testbench RAM takeover and halt

`timescale 1ns/1ps

module system #(
	parameter int WB_DEPTH_LOG2    = 2,
	parameter int RAM_WORDS_LOG2   = 14,
	parameter int HANG_COUNT_WIDTH = 16
) (
	input  logic                      CLK,
	input  logic                      nRST,
	// core side
	input  logic                      iread_ren,
	input  mem_types_pkg::word_t      iread_addr,
	output logic                      iread_hit,
	output mem_types_pkg::word_t      iread_load,
	input  logic                      dread_valid,
	input  mem_types_pkg::daddr_t     dread_addr,
	input  core_types_pkg::lq_index_t dread_tag,
	output logic                      dread_resp_valid,
	output core_types_pkg::lq_index_t dread_resp_tag,
	output mem_types_pkg::word_t      dread_resp_data,
	input  logic                      dwrite_valid,
	input  mem_types_pkg::daddr_t     dwrite_addr,
	input  mem_types_pkg::word_t      dwrite_data,
	output logic                      dwrite_blocked,
	input  logic                      core_halt,
	output logic                      halt,
	// testbench RAM port
	input  logic                      tb_ctrl,
	input  logic                      tb_ren,
	input  logic                      tb_wen,
	input  mem_types_pkg::word_t      tb_addr,
	input  mem_types_pkg::word_t      tb_store,
	output mem_types_pkg::word_t      tb_load
);

	// arbiter side of the RAM port
	logic                 mem_ren;
	logic                 mem_wen;
	mem_types_pkg::word_t mem_addr;
	mem_types_pkg::word_t mem_store;

	// RAM side after takeover mux
	logic                 ram_ren;
	logic                 ram_wen;
	mem_types_pkg::word_t ram_addr;
	mem_types_pkg::word_t ram_store;
	mem_types_pkg::word_t ram_load;

	logic halt_flushed;
	logic hang;

	mem_arbiter #(
		.WB_DEPTH_LOG2(WB_DEPTH_LOG2)
	) arbiter_i (
		.CLK(CLK), .nRST(nRST),
		.iread_ren(iread_ren), .iread_addr(iread_addr),
		.iread_hit(iread_hit), .iread_load(iread_load),
		.dread_valid(dread_valid), .dread_addr(dread_addr), .dread_tag(dread_tag),
		.dread_resp_valid(dread_resp_valid), .dread_resp_tag(dread_resp_tag),
		.dread_resp_data(dread_resp_data),
		.dwrite_valid(dwrite_valid), .dwrite_addr(dwrite_addr),
		.dwrite_data(dwrite_data), .dwrite_blocked(dwrite_blocked),
		.core_halt(core_halt), .halt_flushed(halt_flushed),
		.ram_load(ram_load),
		.mem_ren(mem_ren), .mem_wen(mem_wen), .mem_addr(mem_addr), .mem_store(mem_store)
	);

	ram #(
		.RAM_WORDS_LOG2(RAM_WORDS_LOG2)
	) ram_i (
		.CLK(CLK), .nRST(nRST),
		.ren(ram_ren), .wen(ram_wen), .addr(ram_addr), .store(ram_store),
		.load(ram_load)
	);

	hang_detector #(
		.HANG_COUNT_WIDTH(HANG_COUNT_WIDTH)
	) hang_i (
		.CLK(CLK), .nRST(nRST),
		.hang(hang)
	);

	////////////////////////////////////////////////////////////
	// testbench takeover
	////////////////////////////////////////////////////////////

	// arbiter keeps granting, its RAM requests are dropped
	assign ram_ren   = tb_ctrl ? tb_ren   : mem_ren;
	assign ram_wen   = tb_ctrl ? tb_wen   : mem_wen;
	assign ram_addr  = tb_ctrl ? tb_addr  : mem_addr;
	assign ram_store = tb_ctrl ? tb_store : mem_store;
	assign tb_load   = ram_load;

	// flushed halt or hang timeout
	assign halt = halt_flushed | hang;

endmodule

// File: mem_arbiter/mem_arbiter.sv
// RAM port arbiter: fixed priority dread > drain > ifetch, tagged read response, halt gating

`timescale 1ns/1ps

module mem_arbiter #(
	parameter int WB_DEPTH_LOG2 = 2
) (
	input  logic                      CLK,
	input  logic                      nRST,
	// instruction fetch
	input  logic                      iread_ren,
	input  mem_types_pkg::word_t      iread_addr,
	output logic                      iread_hit,
	output mem_types_pkg::word_t      iread_load,
	// data read
	input  logic                      dread_valid,
	input  mem_types_pkg::daddr_t     dread_addr,
	input  core_types_pkg::lq_index_t dread_tag,
	output logic                      dread_resp_valid,
	output core_types_pkg::lq_index_t dread_resp_tag,
	output mem_types_pkg::word_t      dread_resp_data,
	// data write
	input  logic                      dwrite_valid,
	input  mem_types_pkg::daddr_t     dwrite_addr,
	input  mem_types_pkg::word_t      dwrite_data,
	output logic                      dwrite_blocked,
	// halt
	input  logic                      core_halt,
	output logic                      halt_flushed,
	// RAM port
	input  mem_types_pkg::word_t      ram_load,
	output logic                      mem_ren,
	output logic                      mem_wen,
	output mem_types_pkg::word_t      mem_addr,
	output mem_types_pkg::word_t      mem_store
);

	logic                  wb_full;
	logic                  wb_empty;
	logic                  wb_deq;
	mem_types_pkg::daddr_t wb_head_addr;
	mem_types_pkg::word_t  wb_head_data;
	logic                  wb_hit;
	mem_types_pkg::word_t  wb_hit_data;
	mem_types_pkg::word_t  resp_data_next;

	write_buffer #(
		.WB_DEPTH_LOG2(WB_DEPTH_LOG2)
	) write_buffer_i (
		.CLK         (CLK),
		.nRST        (nRST),
		.enq         (dwrite_valid && !wb_full),
		.enq_addr    (dwrite_addr),
		.enq_data    (dwrite_data),
		.deq         (wb_deq),
		.lookup_addr (dread_addr),
		.full        (wb_full),
		.empty       (wb_empty),
		.head_addr   (wb_head_addr),
		.head_data   (wb_head_data),
		.lookup_hit  (wb_hit),
		.lookup_data (wb_hit_data)
	);

	// blocked straight from registered full
	assign dwrite_blocked = wb_full;
	assign halt_flushed   = core_halt && wb_empty;
	assign iread_load     = ram_load;
	// only the drain writes
	assign mem_store      = wb_head_data;

	////////////////////////////////////////////////////////////
	// priority select
	////////////////////////////////////////////////////////////

	always_comb begin
		mem_ren        = 1'b0;
		mem_wen        = 1'b0;
		mem_addr       = '0;
		wb_deq         = 1'b0;
		iread_hit      = 1'b0;
		resp_data_next = ram_load;
		if (dread_valid) begin
			// forward youngest pending write, else RAM
			if (wb_hit) begin
				resp_data_next = wb_hit_data;
			end else begin
				mem_ren  = 1'b1;
				mem_addr = {mem_types_pkg::DADDR_HI_PAD, dread_addr, mem_types_pkg::DADDR_LO_PAD};
			end
		end else if (!wb_empty) begin
			// drain oldest entry
			mem_wen  = 1'b1;
			mem_addr = {mem_types_pkg::DADDR_HI_PAD, wb_head_addr, mem_types_pkg::DADDR_LO_PAD};
			wb_deq   = 1'b1;
		end else if (iread_ren) begin
			mem_ren   = 1'b1;
			mem_addr  = iread_addr;
			iread_hit = 1'b1;
		end
	end

	// response one cycle after request
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			dread_resp_valid <= 1'b0;
		end else begin
			dread_resp_valid <= dread_valid;
		end
	end

	always_ff @(posedge CLK) begin
		dread_resp_tag  <= dread_tag;
		dread_resp_data <= resp_data_next;
	end

endmodule

// File: mem_arbiter/write_buffer.sv
// posted write queue: circular entries, head/tail with wrap bit, youngest-match lookup

`timescale 1ns/1ps

module write_buffer #(
	parameter int WB_DEPTH_LOG2 = 2
) (
	input  logic                   CLK,
	input  logic                   nRST,
	input  logic                   enq,
	input  mem_types_pkg::daddr_t  enq_addr,
	input  mem_types_pkg::word_t   enq_data,
	input  logic                   deq,
	input  mem_types_pkg::daddr_t  lookup_addr,
	output logic                   full,
	output logic                   empty,
	output mem_types_pkg::daddr_t  head_addr,
	output mem_types_pkg::word_t   head_data,
	output logic                   lookup_hit,
	output mem_types_pkg::word_t   lookup_data
);

	localparam int DEPTH = 1 << WB_DEPTH_LOG2;

	// pointer with one extra wrap bit
	typedef logic [WB_DEPTH_LOG2:0] ptr_t;
	typedef logic [WB_DEPTH_LOG2-1:0] slot_t;

	logic                  entry_valid [DEPTH];
	mem_types_pkg::daddr_t entry_addr  [DEPTH];
	mem_types_pkg::word_t  entry_data  [DEPTH];

	ptr_t  head_ptr;
	ptr_t  tail_ptr;
	slot_t head_slot;
	slot_t tail_slot;
	slot_t scan_slot;

	assign head_slot = head_ptr[WB_DEPTH_LOG2-1:0];
	assign tail_slot = tail_ptr[WB_DEPTH_LOG2-1:0];

	// same slot, wrap bits differ -> full
	assign full  = (head_slot == tail_slot) && (head_ptr[WB_DEPTH_LOG2] != tail_ptr[WB_DEPTH_LOG2]);
	assign empty = (head_ptr == tail_ptr);

	// oldest entry, drained first
	assign head_addr = entry_addr[head_slot];
	assign head_data = entry_data[head_slot];

	////////////////////////////////////////////////////////////
	// control state
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			head_ptr <= '0;
			tail_ptr <= '0;
			for (int i = 0; i < DEPTH; i++) begin
				entry_valid[i] <= 1'b0;
			end
		end else begin
			// enq and deq never hit the same slot
			if (deq) begin
				entry_valid[head_slot] <= 1'b0;
				head_ptr <= head_ptr + 1'b1;
			end
			if (enq) begin
				entry_valid[tail_slot] <= 1'b1;
				tail_ptr <= tail_ptr + 1'b1;
			end
		end
	end

	// payload
	always_ff @(posedge CLK) begin
		if (enq) begin
			entry_addr[tail_slot] <= enq_addr;
			entry_data[tail_slot] <= enq_data;
		end
	end

	////////////////////////////////////////////////////////////
	// lookup
	////////////////////////////////////////////////////////////

	// walk oldest to youngest starting at head
	// a later match overrides, so youngest wins
	always_comb begin
		lookup_hit  = 1'b0;
		lookup_data = '0;
		scan_slot   = head_slot;
		for (int i = 0; i < DEPTH; i++) begin
			scan_slot = head_slot + WB_DEPTH_LOG2'(i);
			if (entry_valid[scan_slot] && (entry_addr[scan_slot] == lookup_addr)) begin
				lookup_hit  = 1'b1;
				lookup_data = entry_data[scan_slot];
			end
		end
	end

endmodule

// File: src.f
common/mem_types_pkg.sv
common/core_types_pkg.sv
mem_arbiter/write_buffer.sv
mem_arbiter/mem_arbiter.sv
design/ram.sv
design/hang_detector.sv
design/system.sv
verif/system_assertions.sv
verif/system_tb.sv

// File: verif/system_assertions.sv
// bound checks on the top-level read, fetch and write handshakes

`timescale 1ns/1ps

module system_assertions (
	input logic CLK,
	input logic nRST,
	input logic dread_valid,
	input logic dread_resp_valid,
	input logic iread_hit,
	input logic dwrite_valid,
	input logic dwrite_blocked
);

	// number of failed assertions
	int fail_count = 0;

	// response exactly one cycle after each read
	read_latency: assert property (@(posedge CLK) disable iff (!nRST)
		1'b1 |=> (dread_resp_valid == $past(dread_valid)))
		else begin
			fail_count++;
			$error("dread_resp_valid does not follow dread_valid by one cycle");
		end

	// data read outranks fetch
	fetch_vs_read: assert property (@(posedge CLK) disable iff (!nRST)
		!(iread_hit && dread_valid))
		else begin
			fail_count++;
			$error("iread_hit granted during a data read");
		end

	// full only after an accepted write
	blocked_after_accept: assert property (@(posedge CLK) disable iff (!nRST)
		$rose(dwrite_blocked) |-> $past(dwrite_valid && !dwrite_blocked))
		else begin
			fail_count++;
			$error("dwrite_blocked rose without an accepted write");
		end

endmodule

bind system system_assertions assertions_i (.*);

// File: verif/system_tb.sv
// system testbench with clock, reset, directed tests, compare tasks, watchdog and summary

`timescale 1ns/1ps

module system_tb;

	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 5;
	localparam int HANG_WIDTH = 9;
	localparam int HANG_LIMIT = 1 << HANG_WIDTH;
	// takeover, write/read, back-pressure, fetch, then the hang wait
	localparam int TEST_CYCLES = 30 + 60 + 50 + 40 + HANG_LIMIT + 20;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + TEST_CYCLES + 100;
	// reads parked here never alias a test write
	localparam mem_types_pkg::daddr_t FAR_ADDR = 14'h3ff0;

	logic CLK = 1'b0;
	logic nRST;
	logic iread_ren;
	logic iread_hit;
	mem_types_pkg::word_t iread_addr;
	mem_types_pkg::word_t iread_load;
	logic dread_valid;
	logic dread_resp_valid;
	mem_types_pkg::daddr_t dread_addr;
	core_types_pkg::lq_index_t dread_tag;
	core_types_pkg::lq_index_t dread_resp_tag;
	mem_types_pkg::word_t dread_resp_data;
	logic dwrite_valid;
	logic dwrite_blocked;
	mem_types_pkg::daddr_t dwrite_addr;
	mem_types_pkg::word_t dwrite_data;
	logic core_halt;
	logic halt;
	logic tb_ctrl;
	logic tb_ren;
	logic tb_wen;
	mem_types_pkg::word_t tb_addr;
	mem_types_pkg::word_t tb_store;
	mem_types_pkg::word_t tb_load;

	// expected RAM contents as the youngest accepted write per word
	mem_types_pkg::word_t ref_mem [1 << 14];
	integer seed = 43972;
	int cycles_after_reset = 0;
	int errors = 0;
	int checks = 0;
	int tests = 0;
	int mark_errors = 0;
	int mark_checks = 0;

	system #(.WB_DEPTH_LOG2(2), .RAM_WORDS_LOG2(14), .HANG_COUNT_WIDTH(HANG_WIDTH)) dut_i (.*);

	always #(CLK_PERIOD / 2) CLK = ~CLK;

	always @(posedge CLK) begin
		if (nRST) begin
			cycles_after_reset <= cycles_after_reset + 1;
		end
	end

	// hard stop if a handshake never completes
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired after %0d cycles", WATCHDOG_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

	//////////////////////////////////////////////////////////////
	// compare tasks
	//////////////////////////////////////////////////////////////

	task automatic word_compare(input string name, input mem_types_pkg::word_t got,
			input mem_types_pkg::word_t want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("mismatch %s: got %h, expected %h", name, got, want);
		end
	endtask

	task automatic tag_compare(input string name, input core_types_pkg::lq_index_t got,
			input core_types_pkg::lq_index_t want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("mismatch %s: got %h, expected %h", name, got, want);
		end
	endtask

	task automatic flag_compare(input string name, input logic got, input logic want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("mismatch %s: got %h, expected %h", name, got, want);
		end
	endtask

	task automatic report_test(input string name);
		tests++;
		$display("%s: %0d checks, %0d errors", name, checks - mark_checks, errors - mark_errors);
		mark_checks = checks;
		mark_errors = errors;
	endtask

	//////////////////////////////////////////////////////////////
	// stimulus helpers
	//////////////////////////////////////////////////////////////

	function automatic mem_types_pkg::word_t byte_addr(input mem_types_pkg::daddr_t a);
		return {mem_types_pkg::DADDR_HI_PAD, a, mem_types_pkg::DADDR_LO_PAD};
	endfunction

	// test writes stay in the low 4k words
	function automatic mem_types_pkg::daddr_t next_addr();
		return mem_types_pkg::daddr_t'($random(seed)) & 14'h0fff;
	endfunction

	task automatic go_idle();
		@(posedge CLK);
		iread_ren    <= 1'b0;
		dread_valid  <= 1'b0;
		dwrite_valid <= 1'b0;
		core_halt    <= 1'b0;
		tb_ctrl      <= 1'b0;
		tb_ren       <= 1'b0;
		tb_wen       <= 1'b0;
	endtask

	task automatic ram_poke(input mem_types_pkg::daddr_t addr, input mem_types_pkg::word_t data);
		@(posedge CLK);
		tb_ctrl  <= 1'b1;
		tb_ren   <= 1'b0;
		tb_wen   <= 1'b1;
		tb_addr  <= byte_addr(addr);
		tb_store <= data;
		ref_mem[addr] = data;
	endtask

	task automatic ram_peek(input mem_types_pkg::daddr_t addr);
		@(posedge CLK);
		tb_ctrl <= 1'b1;
		tb_ren  <= 1'b1;
		tb_wen  <= 1'b0;
		tb_addr <= byte_addr(addr);
		@(negedge CLK);
		word_compare("tb_load", tb_load, ref_mem[addr]);
	endtask

	// returns once the write is seen unblocked
	// accepted on the next edge
	task automatic post_write(input mem_types_pkg::daddr_t addr,
			input mem_types_pkg::word_t data);
		int waited;
		waited = 0;
		@(posedge CLK);
		dwrite_valid <= 1'b1;
		dwrite_addr  <= addr;
		dwrite_data  <= data;
		@(negedge CLK);
		while (dwrite_blocked && waited < 16) begin
			@(negedge CLK);
			waited++;
		end
		if (dwrite_blocked) begin
			errors++;
			$display("write to word %h was never accepted", addr);
		end
		ref_mem[addr] = data;
	endtask

	task automatic tagged_read(input mem_types_pkg::daddr_t addr,
			input core_types_pkg::lq_index_t tag);
		@(posedge CLK);
		dwrite_valid <= 1'b0;
		dread_valid  <= 1'b1;
		dread_addr   <= addr;
		dread_tag    <= tag;
		@(posedge CLK);
		dread_valid <= 1'b0;
		@(negedge CLK);
		flag_compare("dread_resp_valid", dread_resp_valid, 1'b1);
		tag_compare("dread_resp_tag", dread_resp_tag, tag);
		word_compare("dread_resp_data", dread_resp_data, ref_mem[addr]);
	endtask

	// halt with core_halt high means the buffer is empty
	task automatic wait_drained();
		int waited;
		waited = 0;
		@(posedge CLK);
		core_halt <= 1'b1;
		@(negedge CLK);
		while (!halt && waited < 16) begin
			@(negedge CLK);
			waited++;
		end
		if (!halt) begin
			errors++;
			$display("write buffer never drained");
		end
		@(posedge CLK);
		core_halt <= 1'b0;
	endtask

	//////////////////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////////////////

	task automatic takeover_test();
		mem_types_pkg::daddr_t addrs [6];
		for (int i = 0; i < 6; i++) begin
			addrs[i] = next_addr();
			ram_poke(addrs[i], $random(seed));
		end
		for (int i = 0; i < 6; i++) begin
			ram_peek(addrs[i]);
		end
		go_idle();
		report_test("testbench takeover");
	endtask

	task automatic write_read_test();
		mem_types_pkg::daddr_t addrs [4];
		for (int i = 0; i < 4; i++) begin
			addrs[i] = next_addr();
			post_write(addrs[i], $random(seed));
		end
		// parked read stops the drain
		// both same-address writes stay buffered
		@(posedge CLK);
		dwrite_valid <= 1'b0;
		dread_valid  <= 1'b1;
		dread_addr   <= FAR_ADDR;
		dread_tag    <= 3'd7;
		post_write(addrs[1], $random(seed));
		post_write(addrs[1], $random(seed));
		tagged_read(addrs[1], 3'd5);
		for (int i = 0; i < 4; i++) begin
			tagged_read(addrs[i], core_types_pkg::lq_index_t'(i));
		end
		go_idle();
		report_test("write then read");
	endtask

	task automatic backpressure_test();
		mem_types_pkg::daddr_t addrs [5];
		mem_types_pkg::word_t data;
		int waited;
		waited = 0;
		@(posedge CLK);
		dread_valid <= 1'b1;
		dread_addr  <= FAR_ADDR;
		for (int k = 0; k < 5; k++) begin
			addrs[k] = next_addr();
			data = $random(seed);
			@(posedge CLK);
			dwrite_valid <= 1'b1;
			dwrite_addr  <= addrs[k];
			dwrite_data  <= data;
			@(negedge CLK);
			// four accepted
			// the fifth sees a full buffer
			flag_compare("dwrite_blocked", dwrite_blocked, k == 4);
			if (k < 4) begin
				ref_mem[addrs[k]] = data;
			end
		end
		@(posedge CLK);
		dread_valid <= 1'b0;
		@(negedge CLK);
		while (dwrite_blocked && waited < 16) begin
			@(negedge CLK);
			waited++;
		end
		if (dwrite_blocked) begin
			errors++;
			$display("fifth write stayed blocked after reads stopped");
		end
		@(posedge CLK);
		dwrite_valid <= 1'b0;
		ref_mem[addrs[4]] = data;
		wait_drained();
		for (int k = 0; k < 5; k++) begin
			ram_peek(addrs[k]);
		end
		go_idle();
		report_test("back-pressure");
	endtask

	task automatic fetch_halt_test();
		mem_types_pkg::daddr_t addr;
		int waited;
		waited = 0;
		for (int i = 0; i < 3; i++) begin
			addr = next_addr();
			post_write(addr, $random(seed));
		end
		@(posedge CLK);
		dwrite_valid <= 1'b0;
		iread_ren    <= 1'b1;
		iread_addr   <= byte_addr(addr);
		core_halt    <= 1'b1;
		@(negedge CLK);
		// last write accepted on this edge
		// still pending
		flag_compare("iread_hit", iread_hit, 1'b0);
		while (!iread_hit && waited < 16) begin
			flag_compare("halt", halt, 1'b0);
			@(negedge CLK);
			waited++;
		end
		if (!iread_hit) begin
			errors++;
			$display("instruction fetch was never granted");
		end
		flag_compare("halt", halt, 1'b1);
		word_compare("iread_load", iread_load, ref_mem[addr]);
		go_idle();
		report_test("fetch and halt");
	endtask

	task automatic hang_test();
		// core_halt release settles before halt is sampled
		@(negedge CLK);
		while (!halt && cycles_after_reset < HANG_LIMIT + 8) begin
			@(negedge CLK);
		end
		if (!halt) begin
			errors++;
			$display("halt never rose from the hang detector");
		end else if (cycles_after_reset > HANG_LIMIT) begin
			errors++;
			$display("halt rose %0d cycles after reset, later than %0d",
				cycles_after_reset, HANG_LIMIT);
		end
		// sticky
		repeat (8) begin
			@(negedge CLK);
			flag_compare("halt", halt, 1'b1);
		end
		report_test("hang");
	endtask

	//////////////////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////////////////

	initial begin
		for (int i = 0; i < (1 << 14); i++) begin
			ref_mem[i] = '0;
		end
		nRST = 1'b0;
		iread_ren = 1'b0;
		iread_addr = '0;
		dread_valid = 1'b0;
		dread_addr = '0;
		dread_tag = '0;
		dwrite_valid = 1'b0;
		dwrite_addr = '0;
		dwrite_data = '0;
		core_halt = 1'b0;
		tb_ctrl = 1'b0;
		tb_ren = 1'b0;
		tb_wen = 1'b0;
		tb_addr = '0;
		tb_store = '0;
		repeat (RESET_CYCLES) @(posedge CLK);
		nRST <= 1'b1;
		takeover_test();
		write_read_test();
		backpressure_test();
		fetch_halt_test();
		hang_test();
		// bound handshake assertions
		errors += dut_i.assertions_i.fail_count;
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule
